// File: noc_pkg.sv
// Flit format and codes shared by RTL and testbench; mesh coordinates 0..7, N_VIRT_CHN a power of two >= 2
package noc_pkg;

  // ##############################
  // Widths
  // ##############################
  localparam int FLIT_W     = 32;                  // One flit per transfer
  localparam int COORD_W    = 3;                   // Up to an 8x8 mesh
  localparam int ROUTE_W    = 3;                   // Five ports need three bits
  localparam int N_VIRT_CHN = 4;                   // Power of two
  localparam int VC_ID_W    = $clog2(N_VIRT_CHN);

  typedef logic [FLIT_W-1:0]  flit_t;              // Whole flit
  typedef logic [1:0]         flit_type_t;         // Bits 31..30
  typedef logic [COORD_W-1:0] coord_t;             // One mesh coordinate
  typedef logic [VC_ID_W-1:0] vc_id_t;             // Virtual channel number
  typedef logic [ROUTE_W-1:0] route_t;             // Output port code

  // ##############################
  // Field positions
  // ##############################
  // Head flits only, the rest of a head is payload
  localparam int TYPE_LSB   = 30;                  // Flit type
  localparam int DEST_X_LSB = 27;                  // Destination x, bits 29..27
  localparam int DEST_Y_LSB = 24;                  // Destination y, bits 26..24

  // ##############################
  // Codes
  // ##############################
  // Flit types
  localparam flit_type_t FLIT_HEAD      = 2'd0;
  localparam flit_type_t FLIT_BODY      = 2'd1;
  localparam flit_type_t FLIT_TAIL      = 2'd2;
  localparam flit_type_t FLIT_HEAD_TAIL = 2'd3;   // Single-flit packet

  // Output ports
  localparam route_t ROUTE_LOCAL = 3'd0;          // Eject here
  localparam route_t ROUTE_EAST  = 3'd1;          // Toward larger x
  localparam route_t ROUTE_WEST  = 3'd2;          // Toward smaller x
  localparam route_t ROUTE_NORTH = 3'd3;          // Toward larger y
  localparam route_t ROUTE_SOUTH = 3'd4;          // Toward smaller y, highest legal code

endpackage

// File: vc_buffer.sv
// Per-VC flit FIFO; DEPTH must be a power of two and at least 2, storage has no reset
`timescale 1ns/1ps
module vc_buffer #(
  parameter int unsigned DEPTH = 4
) (
  input  logic            clk,
  input  logic            arst_n,
  // Write side
  input  logic            in_valid,
  input  noc_pkg::flit_t  in_data,
  input  noc_pkg::route_t in_route,
  output logic            in_ready,
  // Read side
  output logic            out_valid,
  output noc_pkg::flit_t  out_data,
  output noc_pkg::route_t out_route,
  input  logic            out_ready
);
  import noc_pkg::*;

  localparam int AW = $clog2(DEPTH);    // Address bits

  flit_t       mem_flit  [DEPTH];       // Flit storage
  route_t      mem_route [DEPTH];       // Route travels with its flit
  logic [AW:0] wr_ptr;                  // Extra MSB is the wrap bit
  logic [AW:0] rd_ptr;
  logic        full;
  logic        empty;
  logic        push;
  logic        pop;

  // ##############################
  // Status
  // ##############################
  // Same slot but different wrap bit means full
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign empty = (wr_ptr == rd_ptr);

  assign in_ready  = !full;             // Low only when full
  assign out_valid = !empty;
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  // Head of queue, read straight from storage
  assign out_data  = mem_flit[rd_ptr[AW-1:0]];
  assign out_route = mem_route[rd_ptr[AW-1:0]];

  // ##############################
  // Pointers and storage
  // ##############################
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;                     // Empty after reset
      rd_ptr <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;        // Slot free now, ready sees it next cycle
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem_flit[wr_ptr[AW-1:0]]  <= in_data;
      mem_route[wr_ptr[AW-1:0]] <= in_route;
    end
  end

endmodule

// File: flit_decode.sv
// XY route decode; body flits with no earlier head on their VC take the last route, local after reset
`timescale 1ns/1ps
module flit_decode #(
  parameter noc_pkg::coord_t ROUTER_X = 3'd2,
  parameter noc_pkg::coord_t ROUTER_Y = 3'd2
) (
  input  logic             clk,
  input  logic             arst_n,
  // Incoming flits
  input  logic             fin_valid,
  input  noc_pkg::flit_t   fin_data,
  input  noc_pkg::vc_id_t  fin_vc,
  output logic             fin_ready,
  // Toward the buffers
  output logic             dec_valid,
  output noc_pkg::flit_t   dec_data,
  output noc_pkg::vc_id_t  dec_vc,
  output noc_pkg::route_t  dec_route,
  input  logic             dec_ready
);
  import noc_pkg::*;

  flit_type_t ftype;
  coord_t     dest_x;
  coord_t     dest_y;
  logic       is_head;
  logic       head_acc;
  route_t     head_route;               // XY result for the current flit
  route_t     route_q [N_VIRT_CHN];     // Last head route per VC

  // ##############################
  // Field decode
  // ##############################
  assign ftype   = fin_data[TYPE_LSB +: $bits(flit_type_t)];
  assign dest_x  = fin_data[DEST_X_LSB +: COORD_W];   // Meaningful on heads only
  assign dest_y  = fin_data[DEST_Y_LSB +: COORD_W];
  assign is_head = (ftype == FLIT_HEAD) || (ftype == FLIT_HEAD_TAIL);

  // Head taken by the buffer this cycle
  assign head_acc = fin_valid && dec_ready && is_head;

  // X first, then Y, then eject
  always_comb begin : xy_route
    if (dest_x > ROUTER_X)
      head_route = ROUTE_EAST;
    else if (dest_x < ROUTER_X)
      head_route = ROUTE_WEST;
    else if (dest_y > ROUTER_Y)
      head_route = ROUTE_NORTH;
    else if (dest_y < ROUTER_Y)
      head_route = ROUTE_SOUTH;
    else
      head_route = ROUTE_LOCAL;
  end

  // ##############################
  // Route memory per VC
  // ##############################
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < N_VIRT_CHN; i++) begin
        route_q[i] <= ROUTE_LOCAL;
      end
    end else if (head_acc) begin
      route_q[fin_vc] <= head_route;   // Rest of the packet follows this
    end
  end

  // No extra cycle, only the route is added
  assign dec_valid = fin_valid;
  assign dec_data  = fin_data;
  assign dec_vc    = fin_vc;
  assign dec_route = is_head ? head_route : route_q[fin_vc];  // Heads use the fresh result
  assign fin_ready = dec_ready;

endmodule

// File: input_ctrl.sv
// VC demux into FIFOs and fixed-priority output select; low-priority VCs can starve
`timescale 1ns/1ps
module input_ctrl #(
  parameter int unsigned VC_DEPTH      = 4,
  parameter int unsigned PRIORITY_DESC = 1
) (
  input  logic             clk,
  input  logic             arst_n,
  // From decode
  input  logic             dec_valid,
  input  noc_pkg::flit_t   dec_data,
  input  noc_pkg::vc_id_t  dec_vc,
  input  noc_pkg::route_t  dec_route,
  output logic             dec_ready,
  // Output port
  output logic             fout_valid,
  output noc_pkg::flit_t   fout_data,
  output noc_pkg::vc_id_t  fout_vc,
  output noc_pkg::route_t  fout_route,
  input  logic             fout_ready
);
  import noc_pkg::*;

  logic [N_VIRT_CHN-1:0] buf_in_valid;
  logic [N_VIRT_CHN-1:0] buf_in_ready;
  logic [N_VIRT_CHN-1:0] buf_out_valid;
  logic [N_VIRT_CHN-1:0] buf_out_ready;
  flit_t                 buf_out_data  [N_VIRT_CHN];
  route_t                buf_out_route [N_VIRT_CHN];

  vc_id_t                sel_vc;       // Winning VC
  logic                  sel_found;    // Any buffer has a flit

  // ##############################
  // One FIFO per VC
  // ##############################
  for (genvar v = 0; v < N_VIRT_CHN; v++) begin : g_vc
    // Only the addressed VC sees valid, data goes to all
    assign buf_in_valid[v]  = dec_valid && (dec_vc == vc_id_t'(v));
    // Only the winner sees fout_ready
    assign buf_out_ready[v] = fout_ready && sel_found && (sel_vc == vc_id_t'(v));

    vc_buffer #(
      .DEPTH     (VC_DEPTH)
    ) u_vc_fifo (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (buf_in_valid[v]),
      .in_data   (dec_data),
      .in_route  (dec_route),
      .in_ready  (buf_in_ready[v]),
      .out_valid (buf_out_valid[v]),
      .out_data  (buf_out_data[v]),
      .out_route (buf_out_route[v]),
      .out_ready (buf_out_ready[v])
    );
  end

  assign dec_ready = buf_in_ready[dec_vc];   // Ready of the addressed VC

  // ##############################
  // Output priority select
  // ##############################
  // Descending: each valid VC overwrites, so the highest wins
  // Ascending: the first valid VC is kept
  always_comb begin : out_select
    sel_found = 1'b0;
    sel_vc    = '0;
    for (int i = 0; i < N_VIRT_CHN; i++) begin
      if (buf_out_valid[i]) begin
        if (PRIORITY_DESC != 0 || !sel_found)
          sel_vc = vc_id_t'(i);
        sel_found = 1'b1;
      end
    end
  end

  // Selection may change before accept
  assign fout_valid = sel_found;
  assign fout_data  = buf_out_data[sel_vc];
  assign fout_vc    = sel_vc;
  assign fout_route = buf_out_route[sel_vc];

endmodule

// File: noc_in_port.sv
// Router input port top; one port only, no crossbar or credits, ROUTER_X/Y within the 3-bit mesh
`timescale 1ns/1ps
module noc_in_port #(
  parameter noc_pkg::coord_t ROUTER_X      = 3'd2,
  parameter noc_pkg::coord_t ROUTER_Y      = 3'd2,
  parameter int unsigned     VC_DEPTH      = 4,    // Power of two, at least 2
  parameter int unsigned     PRIORITY_DESC = 1     // 1 means highest VC wins
) (
  input  logic             clk,
  input  logic             arst_n,
  // Flit input
  input  logic             fin_valid,
  input  noc_pkg::flit_t   fin_data,
  input  noc_pkg::vc_id_t  fin_vc,
  output logic             fin_ready,
  // Flit output with its route
  output logic             fout_valid,
  output noc_pkg::flit_t   fout_data,
  output noc_pkg::vc_id_t  fout_vc,
  output noc_pkg::route_t  fout_route,
  input  logic             fout_ready
);
  import noc_pkg::*;

  // Decode to buffers
  logic   dec_valid;
  flit_t  dec_data;
  vc_id_t dec_vc;
  route_t dec_route;
  logic   dec_ready;

  flit_decode #(
    .ROUTER_X  (ROUTER_X),
    .ROUTER_Y  (ROUTER_Y)
  ) u_flit_decode (
    .clk       (clk),
    .arst_n    (arst_n),
    .fin_valid (fin_valid),
    .fin_data  (fin_data),
    .fin_vc    (fin_vc),
    .fin_ready (fin_ready),
    .dec_valid (dec_valid),
    .dec_data  (dec_data),
    .dec_vc    (dec_vc),
    .dec_route (dec_route),
    .dec_ready (dec_ready)
  );

  input_ctrl #(
    .VC_DEPTH      (VC_DEPTH),
    .PRIORITY_DESC (PRIORITY_DESC)
  ) u_input_ctrl (
    .clk        (clk),
    .arst_n     (arst_n),
    .dec_valid  (dec_valid),
    .dec_data   (dec_data),
    .dec_vc     (dec_vc),
    .dec_route  (dec_route),
    .dec_ready  (dec_ready),
    .fout_valid (fout_valid),
    .fout_data  (fout_data),
    .fout_vc    (fout_vc),
    .fout_route (fout_route),
    .fout_ready (fout_ready)
  );

endmodule

// File: noc_in_port_checker.sv
// Handshake and reset assertions for noc_in_port; sampled on the rising clock, idle while arst_n is low
`timescale 1ns/1ps
module noc_in_port_checker (
  input logic            clk,
  input logic            arst_n,
  input logic            fin_valid,
  input noc_pkg::flit_t  fin_data,
  input noc_pkg::vc_id_t fin_vc,
  input logic            fin_ready,
  input logic            fout_valid,
  input noc_pkg::flit_t  fout_data,
  input noc_pkg::vc_id_t fout_vc,
  input noc_pkg::route_t fout_route,
  input logic            fout_ready
);
  import noc_pkg::*;

  // ##############################
  // Reset and input channel
  // ##############################
  // Port comes out of reset empty and open
  a_reset_state: assert property (@(posedge clk) $rose(arst_n) |-> !fout_valid && fin_ready)
    else $error("port not empty and ready after reset");

  // Source holds a refused flit
  a_fin_hold: assert property (@(posedge clk) disable iff (!arst_n)
    fin_valid && !fin_ready |=> fin_valid && $stable(fin_data) && $stable(fin_vc))
    else $error("input flit changed while refused");

  // ##############################
  // Output channel
  // ##############################
  a_route_legal: assert property (@(posedge clk) disable iff (!arst_n)
    fout_valid |-> fout_route <= ROUTE_SOUTH)   // Codes 0..4 only
    else $error("illegal route code on output");

  // Stalled flit stays offered, unchanged unless another VC takes over
  a_out_hold: assert property (@(posedge clk) disable iff (!arst_n)
    fout_valid && !fout_ready |=> fout_valid &&
      ($changed(fout_vc) || ($stable(fout_data) && $stable(fout_route))))
    else $error("stalled output flit dropped or changed");

endmodule

// File: tb_noc_in_port.sv
// Testbench for noc_in_port with default parameters only; random traffic from a fixed seed
`timescale 1ns/1ps
module tb_noc_in_port;
  import noc_pkg::*;

  // ##############################
  // Test setup
  // ##############################
  localparam coord_t ROUTER_X    = 3'd2;        // Default router position
  localparam coord_t ROUTER_Y    = 3'd2;
  localparam int     VC_DEPTH    = 4;
  localparam int     ENT_W       = ROUTE_W + FLIT_W;  // Route above flit
  localparam int     RAND_CYCLES = 600;         // Each random phase
  localparam int     HOLD_CYCLES = 80;          // Output blocked
  localparam int     DRAIN_CYCLES = 100;
  localparam int     MAX_FLITS   = 2 * RAND_CYCLES + HOLD_CYCLES + DRAIN_CYCLES;
  localparam int     TIMEOUT_NS  = 4 * MAX_FLITS * 20 + 2000;

  logic   clk;
  logic   arst_n;
  logic   fin_valid;
  flit_t  fin_data;
  vc_id_t fin_vc;
  logic   fin_ready;
  logic   fout_valid;
  flit_t  fout_data;
  vc_id_t fout_vc;
  route_t fout_route;
  logic   fout_ready;

  logic [ENT_W-1:0] exp_q [N_VIRT_CHN][$];      // Expected flits per VC, oldest first
  route_t model_route [N_VIRT_CHN];             // Last head route per VC
  int     pkt_left [N_VIRT_CHN];                // Flits still owed by the open packet
  logic   pending;                              // Flit on the input not yet taken
  flit_t  cur_flit;
  vc_id_t cur_vc;
  logic [ROUTE_SOUTH:0] routes_seen;            // One bit per route code that left
  int     errors;
  int     flits_in;
  int     flits_out;
  int     seed_ret;

  noc_in_port i_noc_in_port (
    .clk        (clk),
    .arst_n     (arst_n),
    .fin_valid  (fin_valid),
    .fin_data   (fin_data),
    .fin_vc     (fin_vc),
    .fin_ready  (fin_ready),
    .fout_valid (fout_valid),
    .fout_data  (fout_data),
    .fout_vc    (fout_vc),
    .fout_route (fout_route),
    .fout_ready (fout_ready)
  );

  bind noc_in_port noc_in_port_checker i_noc_in_port_checker (
    .clk        (clk),
    .arst_n     (arst_n),
    .fin_valid  (fin_valid),
    .fin_data   (fin_data),
    .fin_vc     (fin_vc),
    .fin_ready  (fin_ready),
    .fout_valid (fout_valid),
    .fout_data  (fout_data),
    .fout_vc    (fout_vc),
    .fout_route (fout_route),
    .fout_ready (fout_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;                     // 20 ns period
  end

  // ##############################
  // Helpers
  // ##############################
  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("mismatch %s: actual %h expected %h at %0t", name, actual, expected, $time);
      errors++;
    end
  endtask

  // X first, then Y, eject when both match
  function automatic route_t xy_route(input coord_t dx, input coord_t dy);
    if (dx > ROUTER_X) return ROUTE_EAST;
    if (dx < ROUTER_X) return ROUTE_WEST;
    if (dy > ROUTER_Y) return ROUTE_NORTH;
    if (dy < ROUTER_Y) return ROUTE_SOUTH;
    return ROUTE_LOCAL;
  endfunction

  // Next flit of a random VC, opens a packet when none is in progress
  task automatic next_flit(output vc_id_t vc, output flit_t flit);
    int         kind;
    flit_type_t ftype;
    vc = vc_id_t'($urandom_range(0, N_VIRT_CHN - 1));
    if (pkt_left[vc] == 0) begin
      kind = $urandom_range(0, 4);              // 4 means single-flit packet
      if (kind == 4) begin
        ftype = FLIT_HEAD_TAIL;
      end else begin
        ftype = FLIT_HEAD;
        pkt_left[vc] = kind + 1;                // Bodies plus the tail
      end
      flit = {ftype, coord_t'($urandom_range(0, 4)), coord_t'($urandom_range(0, 4)),
              24'($urandom())};
    end else begin
      ftype = (pkt_left[vc] == 1) ? FLIT_TAIL : FLIT_BODY;
      pkt_left[vc]--;
      flit = {ftype, 30'($urandom())};
    end
  endtask

  task automatic drive_inputs(input int stall_pct, input bit send);
    if (!pending && send && $urandom_range(0, 99) >= 25) begin  // About 25% idle
      next_flit(cur_vc, cur_flit);
      pending = 1'b1;
    end
    if (pending) begin                          // Held until taken
      fin_valid = 1'b1;
      fin_data  = cur_flit;
      fin_vc    = cur_vc;
    end else begin
      fin_valid = 1'b0;
      fin_data  = $urandom();
      fin_vc    = vc_id_t'($urandom_range(0, N_VIRT_CHN - 1));
    end
    fout_ready = ($urandom_range(0, 99) >= stall_pct);
  endtask

  // Runs at the falling edge, all inputs settled since the last rising edge
  task automatic monitor_cycle();
    logic             exp_valid;
    vc_id_t           exp_vc;
    logic [ENT_W-1:0] ent;
    route_t           in_route;
    flit_type_t       in_type;
    exp_valid = 1'b0;
    exp_vc    = '0;
    for (int v = 0; v < N_VIRT_CHN; v++) begin
      if (exp_q[v].size() > 0) begin
        exp_valid = 1'b1;
        exp_vc    = vc_id_t'(v);                // Highest nonempty VC wins
      end
    end
    check_value("fout_valid", 32'(fout_valid), 32'(exp_valid));
    if (exp_valid)
      check_value("fout_vc", 32'(fout_vc), 32'(exp_vc));
    check_value("fin_ready", 32'(fin_ready), 32'(exp_q[fin_vc].size() < VC_DEPTH));
    // Output handshake
    if (fout_valid && fout_ready) begin
      if (exp_q[fout_vc].size() > 0) begin
        ent = exp_q[fout_vc].pop_front();
        check_value("fout_data", fout_data, ent[FLIT_W-1:0]);
        check_value("fout_route", 32'(fout_route), 32'(ent[ENT_W-1:FLIT_W]));
        routes_seen[ent[ENT_W-1:FLIT_W]] = 1'b1;
        flits_out++;
      end else begin
        $display("Flit left on VC %0d while none was expected at %0t", fout_vc, $time);
        errors++;
      end
    end
    // Input handshake, route rule applied to heads
    if (fin_valid && fin_ready) begin
      in_type = fin_data[TYPE_LSB +: 2];
      if (in_type == FLIT_HEAD || in_type == FLIT_HEAD_TAIL)
        model_route[fin_vc] = xy_route(fin_data[DEST_X_LSB +: COORD_W],
                                       fin_data[DEST_Y_LSB +: COORD_W]);
      in_route = model_route[fin_vc];
      exp_q[fin_vc].push_back({in_route, fin_data});
      pending = 1'b0;
      flits_in++;
      if (exp_q[fin_vc].size() > VC_DEPTH) begin
        $display("VC %0d accepted more flits than its buffer holds", fin_vc);
        errors++;
      end
    end
  endtask

  task automatic run_cycles(input int n, input int stall_pct, input bit send);
    repeat (n) begin
      @(posedge clk);
      #2;                                       // Drive just after the edge
      drive_inputs(stall_pct, send);
      @(negedge clk);
      monitor_cycle();
    end
  endtask

  // ##############################
  // Main sequence
  // ##############################
  initial begin : main
    seed_ret    = $urandom(32'hea2e);
    fin_valid   = 1'b0;
    fin_data    = '0;
    fin_vc      = '0;
    fout_ready  = 1'b0;
    arst_n      = 1'b0;
    pending     = 1'b0;
    routes_seen = '0;
    errors      = 0;
    flits_in    = 0;
    flits_out   = 0;
    for (int v = 0; v < N_VIRT_CHN; v++) begin
      model_route[v] = ROUTE_LOCAL;             // Matches reset of the route registers
      pkt_left[v]    = 0;
    end
    repeat (5) @(posedge clk);
    #2 arst_n = 1'b1;
    @(negedge clk);
    check_value("fout_valid", 32'(fout_valid), 32'd0);  // Empty, no input yet
    check_value("fin_ready", 32'(fin_ready), 32'd1);
    run_cycles(RAND_CYCLES, 30, 1'b1);
    run_cycles(HOLD_CYCLES, 100, 1'b1);         // Buffers fill up
    run_cycles(RAND_CYCLES, 30, 1'b1);
    run_cycles(DRAIN_CYCLES, 0, 1'b0);          // Only a held flit still goes in
    if (pending) begin
      $display("Input flit still waiting after the drain");
      errors++;
    end
    for (int v = 0; v < N_VIRT_CHN; v++) begin
      if (exp_q[v].size() != 0) begin
        $display("VC %0d still expects %0d flits after the drain", v, exp_q[v].size());
        errors++;
      end
    end
    if (!(&routes_seen)) begin                  // Every direction incl. local must leave
      $display("Not every output direction was exercised, seen mask %b", routes_seen);
      errors++;
    end
    $display("errors %0d, flits in %0d, flits out %0d", errors, flits_in, flits_out);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout: the run did not end within %0d ns", TIMEOUT_NS);
    $display("Finished with errors");
    $finish;
  end

endmodule

// File: src.f
noc_pkg.sv
vc_buffer.sv
flit_decode.sv
input_ctrl.sv
noc_in_port.sv
noc_in_port_checker.sv
tb_noc_in_port.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the noc_in_port testbench with Verilator.
# The result is taken from the simulation log.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module tb_noc_in_port \
  -f src.f \
  -o Vtb_noc_in_port

./obj_dir/Vtb_noc_in_port 2>&1 | tee "$LOG"

if grep -q "Finished with no errors" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see $LOG"
  exit 1
fi
